//--- build.f
rtl/tlul_pkg.sv
rtl/sram_pkg.sv
rtl/prim_ram_1p.sv
rtl/tlul_adapter_sram.sv
rtl/tlul_socket_1n.sv
rtl/sim_sram.sv
verif/sim_sram_tb.sv

//--- rtl/prim_ram_1p.sv
/*
 * Single-port RAM with bit write mask.
 * Read data is registered and appears one cycle after the request.
 */

`timescale 1ns/1ps

module prim_ram_1p import sram_pkg::*; #(
  parameter int Depth = 8
) (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic                            write_i,
  input  logic [$clog2(Depth)-1:0]        addr_i,
  input  logic [8*SramBytesPerWord-1:0]   wdata_i,
  input  logic [8*SramBytesPerWord-1:0]   wmask_i,
  output logic [8*SramBytesPerWord-1:0]   rdata_o
);

  localparam int Width = 8 * SramBytesPerWord;

  logic [Width-1:0] mem_q [Depth];

  // Masked-off bits keep their old value.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

//--- rtl/sim_sram.sv
/*
 * Simulation memory window on an outbound TL-UL port.
 * Requests inside the window go to a local SRAM, all others pass to the outbound port.
 */

`timescale 1ns/1ps

module sim_sram import tlul_pkg::*, sram_pkg::*; #(
  parameter int Depth          = 8,
  parameter int Outstanding    = 2,
  parameter int MaxOutstanding = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [TlAw-1:0] start_addr_i,
  // Host port.
  input  logic            host_a_valid_i,
  input  logic [2:0]      host_a_opcode_i,
  input  logic [TlAw-1:0] host_a_address_i,
  input  logic [TlMw-1:0] host_a_mask_i,
  input  logic [TlDw-1:0] host_a_data_i,
  input  logic [TlSw-1:0] host_a_source_i,
  output logic            host_a_ready_o,
  output logic            host_d_valid_o,
  output logic [2:0]      host_d_opcode_o,
  output logic [TlDw-1:0] host_d_data_o,
  output logic [TlSw-1:0] host_d_source_o,
  output logic            host_d_error_o,
  input  logic            host_d_ready_i,
  // Outbound port.
  output logic            out_a_valid_o,
  output logic [2:0]      out_a_opcode_o,
  output logic [TlAw-1:0] out_a_address_o,
  output logic [TlMw-1:0] out_a_mask_o,
  output logic [TlDw-1:0] out_a_data_o,
  output logic [TlSw-1:0] out_a_source_o,
  input  logic            out_a_ready_i,
  input  logic            out_d_valid_i,
  input  logic [2:0]      out_d_opcode_i,
  input  logic [TlDw-1:0] out_d_data_i,
  input  logic [TlSw-1:0] out_d_source_i,
  input  logic            out_d_error_i,
  output logic            out_d_ready_o
);

  localparam int              Aw          = $clog2(Depth);
  localparam logic [TlAw-1:0] WindowBytes = TlAw'(Depth * SramBytesPerWord);

  if ((Depth & (Depth - 1)) != 0) begin : gen_depth_check
    $error("Depth must be a power of two");
  end

  logic            dev_select;
  logic [TlAw-1:0] window_off;

  logic            adp_a_valid;
  logic [2:0]      adp_a_opcode;
  logic [TlAw-1:0] adp_a_address;
  logic [TlMw-1:0] adp_a_mask;
  logic [TlDw-1:0] adp_a_data;
  logic [TlSw-1:0] adp_a_source;
  logic            adp_a_ready;
  logic            adp_d_valid;
  logic [2:0]      adp_d_opcode;
  logic [TlDw-1:0] adp_d_data;
  logic [TlSw-1:0] adp_d_source;
  logic            adp_d_error;
  logic            adp_d_ready;

  logic            ram_req;
  logic            ram_we;
  logic [Aw-1:0]   ram_addr;
  logic [TlDw-1:0] ram_wdata;
  logic [TlDw-1:0] ram_wmask;
  logic [TlDw-1:0] ram_rdata;

  // Offset compare avoids wrap when the window ends at the top of the address space.
  assign window_off = host_a_address_i - start_addr_i;
  assign dev_select = (host_a_address_i >= start_addr_i) && (window_off < WindowBytes);

  tlul_socket_1n #(
    .MaxOutstanding(MaxOutstanding)
  ) u_socket (
    .clk_i,
    .rst_ni,
    .dev_select_i  (dev_select),
    .h_a_valid_i   (host_a_valid_i),
    .h_a_opcode_i  (host_a_opcode_i),
    .h_a_address_i (host_a_address_i),
    .h_a_mask_i    (host_a_mask_i),
    .h_a_data_i    (host_a_data_i),
    .h_a_source_i  (host_a_source_i),
    .h_a_ready_o   (host_a_ready_o),
    .h_d_valid_o   (host_d_valid_o),
    .h_d_opcode_o  (host_d_opcode_o),
    .h_d_data_o    (host_d_data_o),
    .h_d_source_o  (host_d_source_o),
    .h_d_error_o   (host_d_error_o),
    .h_d_ready_i   (host_d_ready_i),
    .d0_a_valid_o  (out_a_valid_o),
    .d0_a_opcode_o (out_a_opcode_o),
    .d0_a_address_o(out_a_address_o),
    .d0_a_mask_o   (out_a_mask_o),
    .d0_a_data_o   (out_a_data_o),
    .d0_a_source_o (out_a_source_o),
    .d0_a_ready_i  (out_a_ready_i),
    .d0_d_valid_i  (out_d_valid_i),
    .d0_d_opcode_i (out_d_opcode_i),
    .d0_d_data_i   (out_d_data_i),
    .d0_d_source_i (out_d_source_i),
    .d0_d_error_i  (out_d_error_i),
    .d0_d_ready_o  (out_d_ready_o),
    .d1_a_valid_o  (adp_a_valid),
    .d1_a_opcode_o (adp_a_opcode),
    .d1_a_address_o(adp_a_address),
    .d1_a_mask_o   (adp_a_mask),
    .d1_a_data_o   (adp_a_data),
    .d1_a_source_o (adp_a_source),
    .d1_a_ready_i  (adp_a_ready),
    .d1_d_valid_i  (adp_d_valid),
    .d1_d_opcode_i (adp_d_opcode),
    .d1_d_data_i   (adp_d_data),
    .d1_d_source_i (adp_d_source),
    .d1_d_error_i  (adp_d_error),
    .d1_d_ready_o  (adp_d_ready)
  );

  tlul_adapter_sram #(
    .Depth      (Depth),
    .Outstanding(Outstanding)
  ) u_adapter (
    .clk_i,
    .rst_ni,
    .a_valid_i  (adp_a_valid),
    .a_opcode_i (adp_a_opcode),
    .a_address_i(adp_a_address),
    .a_mask_i   (adp_a_mask),
    .a_data_i   (adp_a_data),
    .a_source_i (adp_a_source),
    .a_ready_o  (adp_a_ready),
    .d_valid_o  (adp_d_valid),
    .d_opcode_o (adp_d_opcode),
    .d_data_o   (adp_d_data),
    .d_source_o (adp_d_source),
    .d_error_o  (adp_d_error),
    .d_ready_i  (adp_d_ready),
    .req_o      (ram_req),
    .we_o       (ram_we),
    .addr_o     (ram_addr),
    .wdata_o    (ram_wdata),
    .wmask_o    (ram_wmask),
    .rdata_i    (ram_rdata)
  );

  prim_ram_1p #(
    .Depth(Depth)
  ) u_ram (
    .clk_i,
    .req_i  (ram_req),
    .write_i(ram_we),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .wmask_i(ram_wmask),
    .rdata_o(ram_rdata)
  );

  // A misaligned window would split words across the decode boundary.
  start_addr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_addr_i[SramByteOffW-1:0] == '0)
    else $error("start_addr_i is not word aligned");

endmodule

//--- rtl/sram_pkg.sv
/*
 * SRAM path geometry and the byte to bit mask expansion.
 */

package sram_pkg;

  parameter int SramBytesPerWord = 4;
  parameter int SramByteOffW     = 2;

  // Every set byte enable covers its eight data bits.
  function automatic logic [8*SramBytesPerWord-1:0] sram_bitmask(
    input logic [SramBytesPerWord-1:0] byte_mask
  );
    logic [8*SramBytesPerWord-1:0] bit_mask;
    for (int i = 0; i < SramBytesPerWord; i++) begin
      bit_mask[8*i +: 8] = {8{byte_mask[i]}};
    end
    return bit_mask;
  endfunction

endpackage

//--- rtl/tlul_adapter_sram.sv
/*
 * TL-UL to single-port SRAM adapter.
 * Issues RAM accesses for Put and Get, answers other opcodes with an error,
 * and holds responses in a small queue until the host takes them.
 */

`timescale 1ns/1ps

module tlul_adapter_sram import tlul_pkg::*, sram_pkg::*; #(
  parameter int Depth       = 8,
  parameter int Outstanding = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Bus side.
  input  logic                     a_valid_i,
  input  logic [2:0]               a_opcode_i,
  input  logic [TlAw-1:0]          a_address_i,
  input  logic [TlMw-1:0]          a_mask_i,
  input  logic [TlDw-1:0]          a_data_i,
  input  logic [TlSw-1:0]          a_source_i,
  output logic                     a_ready_o,
  output logic                     d_valid_o,
  output logic [2:0]               d_opcode_o,
  output logic [TlDw-1:0]          d_data_o,
  output logic [TlSw-1:0]          d_source_o,
  output logic                     d_error_o,
  input  logic                     d_ready_i,
  // RAM side.
  output logic                     req_o,
  output logic                     we_o,
  output logic [$clog2(Depth)-1:0] addr_o,
  output logic [TlDw-1:0]          wdata_o,
  output logic [TlDw-1:0]          wmask_o,
  input  logic [TlDw-1:0]          rdata_i
);

  localparam int Aw   = $clog2(Depth);
  localparam int PtrW = (Outstanding > 1) ? $clog2(Outstanding) : 1;
  localparam int CntW = $clog2(Outstanding + 1);

  logic            a_fire;
  logic            is_put;
  logic            is_get;
  logic            is_bad;
  logic            d_fire;
  logic            q_empty;
  logic            push;
  logic            pop;
  tl_d_op_e        d_opcode;

  // Response stage one cycle behind acceptance, aligned with the RAM read data.
  logic            pend_valid_q;
  tl_d_op_e        pend_op_q;
  logic [TlSw-1:0] pend_source_q;
  logic            pend_error_q;
  logic [TlDw-1:0] pend_data;

  tl_d_op_e        q_op_q     [Outstanding];
  logic [TlDw-1:0] q_data_q   [Outstanding];
  logic [TlSw-1:0] q_source_q [Outstanding];
  logic            q_error_q  [Outstanding];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] q_count_q;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Outstanding - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign is_put = (a_opcode_i == PutFullData) || (a_opcode_i == PutPartialData);
  assign is_get = (a_opcode_i == Get);
  assign is_bad = ~is_put & ~is_get;

  // Room is counted over the queue plus the response stage.
  assign a_ready_o = (int'(q_count_q) + int'(pend_valid_q)) < Outstanding;
  assign a_fire    = a_valid_i & a_ready_o;

  assign req_o   = a_fire & ~is_bad;
  assign we_o    = is_put;
  assign addr_o  = a_address_i[SramByteOffW +: Aw];
  assign wdata_o = a_data_i;
  assign wmask_o = sram_bitmask(a_mask_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_valid_q <= 1'b0;
    end else begin
      pend_valid_q <= a_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      pend_op_q     <= is_get ? AccessAckData : AccessAck;
      pend_source_q <= a_source_i;
      pend_error_q  <= is_bad;
    end
  end

  assign pend_data = (pend_op_q == AccessAckData) ? rdata_i : '0;

  assign q_empty = (q_count_q == '0);

  // An empty queue lets the response stage through directly.
  always_comb begin
    if (q_empty) begin
      d_opcode   = pend_op_q;
      d_data_o   = pend_data;
      d_source_o = pend_source_q;
      d_error_o  = pend_error_q;
    end else begin
      d_opcode   = q_op_q[rd_ptr_q];
      d_data_o   = q_data_q[rd_ptr_q];
      d_source_o = q_source_q[rd_ptr_q];
      d_error_o  = q_error_q[rd_ptr_q];
    end
  end

  assign d_opcode_o = d_opcode;
  assign d_valid_o  = ~q_empty | pend_valid_q;
  assign d_fire     = d_valid_o & d_ready_i;
  assign pop        = d_fire & ~q_empty;
  assign push       = pend_valid_q & ~(q_empty & d_fire);

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_op_q[wr_ptr_q]     <= pend_op_q;
      q_data_q[wr_ptr_q]   <= pend_data;
      q_source_q[wr_ptr_q] <= pend_source_q;
      q_error_q[wr_ptr_q]  <= pend_error_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      q_count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   q_count_q <= q_count_q + 1'b1;
        2'b01:   q_count_q <= q_count_q - 1'b1;
        default: q_count_q <= q_count_q;
      endcase
    end
  end

  // The a_ready rule must keep the queue from ever being pushed when full.
  rsp_queue_overflow_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push && !pop |-> q_count_q < CntW'(Outstanding))
    else $error("Response queue overflow");

endmodule

//--- rtl/tlul_pkg.sv
/*
 * Reduced TL-UL bus definitions.
 * Field widths plus the A and D channel opcode encodings.
 */

package tlul_pkg;

  // Field widths of the host, outbound and device ports.
  parameter int TlAw = 32;
  parameter int TlDw = 32;
  parameter int TlSw = 8;
  parameter int TlMw = TlDw / 8;

  // Requests. Only full 32-bit words are carried.
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // Responses. Data only comes back for a Get.
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

endpackage

//--- rtl/tlul_socket_1n.sv
/*
 * One host to two device TL-UL steering.
 * Counts requests in flight and returns the D channel of the device that owns them.
 */

`timescale 1ns/1ps

module tlul_socket_1n import tlul_pkg::*; #(
  parameter int MaxOutstanding = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            dev_select_i,
  // Host side.
  input  logic            h_a_valid_i,
  input  logic [2:0]      h_a_opcode_i,
  input  logic [TlAw-1:0] h_a_address_i,
  input  logic [TlMw-1:0] h_a_mask_i,
  input  logic [TlDw-1:0] h_a_data_i,
  input  logic [TlSw-1:0] h_a_source_i,
  output logic            h_a_ready_o,
  output logic            h_d_valid_o,
  output logic [2:0]      h_d_opcode_o,
  output logic [TlDw-1:0] h_d_data_o,
  output logic [TlSw-1:0] h_d_source_o,
  output logic            h_d_error_o,
  input  logic            h_d_ready_i,
  // Device 0.
  output logic            d0_a_valid_o,
  output logic [2:0]      d0_a_opcode_o,
  output logic [TlAw-1:0] d0_a_address_o,
  output logic [TlMw-1:0] d0_a_mask_o,
  output logic [TlDw-1:0] d0_a_data_o,
  output logic [TlSw-1:0] d0_a_source_o,
  input  logic            d0_a_ready_i,
  input  logic            d0_d_valid_i,
  input  logic [2:0]      d0_d_opcode_i,
  input  logic [TlDw-1:0] d0_d_data_i,
  input  logic [TlSw-1:0] d0_d_source_i,
  input  logic            d0_d_error_i,
  output logic            d0_d_ready_o,
  // Device 1.
  output logic            d1_a_valid_o,
  output logic [2:0]      d1_a_opcode_o,
  output logic [TlAw-1:0] d1_a_address_o,
  output logic [TlMw-1:0] d1_a_mask_o,
  output logic [TlDw-1:0] d1_a_data_o,
  output logic [TlSw-1:0] d1_a_source_o,
  input  logic            d1_a_ready_i,
  input  logic            d1_d_valid_i,
  input  logic [2:0]      d1_d_opcode_i,
  input  logic [TlDw-1:0] d1_d_data_i,
  input  logic [TlSw-1:0] d1_d_source_i,
  input  logic            d1_d_error_i,
  output logic            d1_d_ready_o
);

  localparam int CntW = $clog2(MaxOutstanding + 1);

  logic [CntW-1:0] cnt_q;
  logic            sel_q;
  logic            busy;
  logic            hold;
  logic            a_fire;
  logic            d_fire;

  assign busy = (cnt_q != '0);

  // Stall when full, or when switching devices would reorder responses.
  assign hold = (cnt_q == CntW'(MaxOutstanding)) || (busy && (sel_q != dev_select_i));

  assign d0_a_valid_o = h_a_valid_i & ~dev_select_i & ~hold;
  assign d1_a_valid_o = h_a_valid_i & dev_select_i & ~hold;
  assign h_a_ready_o  = ~hold & (dev_select_i ? d1_a_ready_i : d0_a_ready_i);

  // The A payload is shared, only valid is steered.
  assign d0_a_opcode_o  = h_a_opcode_i;
  assign d0_a_address_o = h_a_address_i;
  assign d0_a_mask_o    = h_a_mask_i;
  assign d0_a_data_o    = h_a_data_i;
  assign d0_a_source_o  = h_a_source_i;
  assign d1_a_opcode_o  = h_a_opcode_i;
  assign d1_a_address_o = h_a_address_i;
  assign d1_a_mask_o    = h_a_mask_i;
  assign d1_a_data_o    = h_a_data_i;
  assign d1_a_source_o  = h_a_source_i;

  // Responses come from the device that owns the outstanding requests.
  assign h_d_valid_o  = busy & (sel_q ? d1_d_valid_i : d0_d_valid_i);
  assign h_d_opcode_o = sel_q ? d1_d_opcode_i : d0_d_opcode_i;
  assign h_d_data_o   = sel_q ? d1_d_data_i : d0_d_data_i;
  assign h_d_source_o = sel_q ? d1_d_source_i : d0_d_source_i;
  assign h_d_error_o  = sel_q ? d1_d_error_i : d0_d_error_i;
  assign d0_d_ready_o = h_d_ready_i & busy & ~sel_q;
  assign d1_d_ready_o = h_d_ready_i & busy & sel_q;

  assign a_fire = h_a_valid_i & h_a_ready_o;
  assign d_fire = h_d_valid_o & h_d_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      sel_q <= 1'b0;
    end else begin
      if (a_fire) begin
        sel_q <= dev_select_i;
      end
      case ({a_fire, d_fire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // A device only answers while it owns requests in flight.
  no_stray_response_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (d0_d_valid_i || d1_d_valid_i) |-> busy && (sel_q ? !d0_d_valid_i : !d1_d_valid_i))
    else $error("D beat from a device without outstanding requests");

endmodule

//--- verif/sim_sram_tb.sv
/*
 * Testbench for the simulation memory window.
 * Directed table, random mixed traffic, outbound device model,
 * reference memory and an in-order response scoreboard.
 */

`timescale 1ns/1ps

module sim_sram_tb import tlul_pkg::*; ();

  localparam int              Depth      = 8;
  localparam logic [TlAw-1:0] StartAddr  = 32'h1000_0000;
  localparam logic [TlDw-1:0] OutXor     = 32'hA5A5_5A5A;
  localparam int              Timeout    = 200;
  localparam int              RandomReqs = 24;

  logic            clk_i;
  logic            rst_ni;
  logic [TlAw-1:0] start_addr_i;
  logic            host_a_valid_i;
  logic [2:0]      host_a_opcode_i;
  logic [TlAw-1:0] host_a_address_i;
  logic [TlMw-1:0] host_a_mask_i;
  logic [TlDw-1:0] host_a_data_i;
  logic [TlSw-1:0] host_a_source_i;
  logic            host_a_ready_o;
  logic            host_d_valid_o;
  logic [2:0]      host_d_opcode_o;
  logic [TlDw-1:0] host_d_data_o;
  logic [TlSw-1:0] host_d_source_o;
  logic            host_d_error_o;
  logic            host_d_ready_i;
  logic            out_a_valid_o;
  logic [2:0]      out_a_opcode_o;
  logic [TlAw-1:0] out_a_address_o;
  logic [TlMw-1:0] out_a_mask_o;
  logic [TlDw-1:0] out_a_data_o;
  logic [TlSw-1:0] out_a_source_o;
  logic            out_a_ready_i;
  logic            out_d_valid_i;
  logic [2:0]      out_d_opcode_i;
  logic [TlDw-1:0] out_d_data_i;
  logic [TlSw-1:0] out_d_source_i;
  logic            out_d_error_i;
  logic            out_d_ready_o;

  integer          seed;
  int              errors;
  int              checks;
  logic [TlSw-1:0] next_src;
  logic            rand_ready;
  logic [TlDw-1:0] ref_mem [Depth];

  // Expected host responses, oldest first.
  logic [2:0]      exp_op_q   [$];
  logic [TlDw-1:0] exp_data_q [$];
  logic [TlSw-1:0] exp_src_q  [$];
  logic            exp_err_q  [$];

  // Requests the outbound model still has to answer.
  logic [TlAw-1:0] ob_addr_q [$];
  logic [2:0]      ob_op_q   [$];
  logic [TlSw-1:0] ob_src_q  [$];
  logic            ob_active;
  int              ob_wait;
  int              ob_held;

  // Directed table with hand-worked expected values.
  logic [2:0]      tbl_op   [$];
  logic [TlAw-1:0] tbl_addr [$];
  logic [TlMw-1:0] tbl_mask [$];
  logic [TlDw-1:0] tbl_data [$];
  logic [TlDw-1:0] tbl_exp  [$];
  logic            tbl_err  [$];

  // Random traffic, drawn before the clock starts.
  logic [2:0]      rnd_op   [RandomReqs];
  logic [TlAw-1:0] rnd_addr [RandomReqs];
  logic [TlMw-1:0] rnd_mask [RandomReqs];
  logic [TlDw-1:0] rnd_data [RandomReqs];

  sim_sram #(
    .Depth(Depth)
  ) dut_i (
    .*
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  function automatic logic in_window(input logic [TlAw-1:0] addr);
    return (addr >= StartAddr) && ((addr - StartAddr) < 32'(4 * Depth));
  endfunction

  function automatic int ref_index(input logic [TlAw-1:0] addr);
    return int'((addr - StartAddr) >> 2);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic add_entry(input logic [2:0] op, input logic [TlAw-1:0] addr,
                           input logic [TlMw-1:0] mask, input logic [TlDw-1:0] data,
                           input logic [TlDw-1:0] exp, input logic err);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_mask.push_back(mask);
    tbl_data.push_back(data);
    tbl_exp.push_back(exp);
    tbl_err.push_back(err);
  endtask

  // Drives one A beat until accepted and records the response it should get.
  task automatic issue(input logic [2:0] op, input logic [TlAw-1:0] addr,
                       input logic [TlMw-1:0] mask, input logic [TlDw-1:0] data,
                       input logic [TlDw-1:0] exp_data, input logic exp_err);
    int              waited;
    logic            accepted;
    logic [TlDw-1:0] bits;
    host_a_valid_i   = 1'b1;
    host_a_opcode_i  = op;
    host_a_address_i = addr;
    host_a_mask_i    = mask;
    host_a_data_i    = data;
    host_a_source_i  = next_src;
    waited           = 0;
    accepted         = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = host_a_ready_o;
      waited++;
      if (!accepted && waited >= Timeout) begin
        fail_timeout("host_a_ready_o");
      end
    end
    exp_op_q.push_back((op == Get) ? AccessAckData : AccessAck);
    exp_data_q.push_back(exp_data);
    exp_src_q.push_back(next_src);
    exp_err_q.push_back(exp_err);
    // Writes land in the reference memory in acceptance order.
    if (in_window(addr) && (op == PutFullData || op == PutPartialData)) begin
      bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
      ref_mem[ref_index(addr)] = (ref_mem[ref_index(addr)] & ~bits) | (data & bits);
    end
    #1;
    host_a_valid_i = 1'b0;
    next_src++;
  endtask

  task automatic predict_and_issue(input logic [2:0] op, input logic [TlAw-1:0] addr,
                                   input logic [TlMw-1:0] mask, input logic [TlDw-1:0] data);
    logic [TlDw-1:0] exp_data;
    logic            exp_err;
    exp_err = in_window(addr) && (op != PutFullData) && (op != PutPartialData) && (op != Get);
    if (!in_window(addr)) begin
      exp_data = addr ^ OutXor;
    end else if (op == Get) begin
      exp_data = ref_mem[ref_index(addr)];
    end else begin
      exp_data = '0;
    end
    issue(op, addr, mask, data, exp_data, exp_err);
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_op_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (exp_op_q.size() != 0 && waited >= Timeout) begin
        fail_timeout("outstanding host responses");
      end
    end
  endtask

  // Scoreboard for the host D channel.
  always @(posedge clk_i) begin : host_d_monitor
    if (rst_ni && host_d_valid_o && host_d_ready_i) begin
      assert (exp_op_q.size() != 0) else begin
        errors++;
        $display("Host response arrived with no request outstanding");
      end
      if (exp_op_q.size() != 0) begin
        check_eq("host_d_opcode_o", host_d_opcode_o, exp_op_q.pop_front());
        check_eq("host_d_data_o", host_d_data_o, exp_data_q.pop_front());
        check_eq("host_d_source_o", host_d_source_o, exp_src_q.pop_front());
        check_eq("host_d_error_o", host_d_error_o, exp_err_q.pop_front());
      end
    end
  end

  // Outbound device with a random response delay, plus host back-pressure.
  always @(posedge clk_i) begin : outbound_model
    if (out_a_valid_o && out_a_ready_i) begin
      check_eq("out_a_opcode_o", out_a_opcode_o, host_a_opcode_i);
      check_eq("out_a_address_o", out_a_address_o, host_a_address_i);
      check_eq("out_a_mask_o", out_a_mask_o, host_a_mask_i);
      check_eq("out_a_data_o", out_a_data_o, host_a_data_i);
      check_eq("out_a_source_o", out_a_source_o, host_a_source_i);
      ob_addr_q.push_back(out_a_address_o);
      ob_op_q.push_back(out_a_opcode_o);
      ob_src_q.push_back(out_a_source_o);
    end
    if (out_d_valid_i && out_d_ready_o) begin
      ob_addr_q.delete(0);
      ob_op_q.delete(0);
      ob_src_q.delete(0);
      ob_active = 1'b0;
      ob_held   = 0;
    end else if (out_d_valid_i) begin
      ob_held++;
      if (ob_held >= Timeout) begin
        fail_timeout("out_d_ready_o");
      end
    end
    #1;
    if (rand_ready) begin
      host_d_ready_i = ($random(seed) & 1) != 0;
    end
    if (!ob_active && ob_addr_q.size() != 0) begin
      ob_active = 1'b1;
      ob_wait   = $random(seed) & 3;
    end
    if (ob_active && ob_wait == 0) begin
      out_d_valid_i  = 1'b1;
      out_d_opcode_i = (ob_op_q[0] == Get) ? AccessAckData : AccessAck;
      out_d_data_i   = ob_addr_q[0] ^ OutXor;
      out_d_source_i = ob_src_q[0];
      out_d_error_i  = 1'b0;
    end else begin
      out_d_valid_i = 1'b0;
      if (ob_active) begin
        ob_wait--;
      end
    end
  end

  initial begin : main
    logic [31:0]     r;
    logic [TlAw-1:0] addr;
    seed             = 32'h024efa32;
    errors           = 0;
    checks           = 0;
    next_src         = '0;
    rand_ready       = 1'b0;
    ob_active        = 1'b0;
    ob_wait          = 0;
    ob_held          = 0;
    rst_ni           = 1'b0;
    start_addr_i     = StartAddr;
    host_a_valid_i   = 1'b0;
    host_a_opcode_i  = '0;
    host_a_address_i = '0;
    host_a_mask_i    = '0;
    host_a_data_i    = '0;
    host_a_source_i  = '0;
    host_d_ready_i   = 1'b1;
    out_a_ready_i    = 1'b1;
    out_d_valid_i    = 1'b0;
    out_d_opcode_i   = '0;
    out_d_data_i     = '0;
    out_d_source_i   = '0;
    out_d_error_i    = 1'b0;

    // Full writes, then partial writes merged on top.
    add_entry(PutFullData,    32'h1000_0000, 4'hF, 32'h1122_3344, 32'h0000_0000, 1'b0);
    add_entry(PutFullData,    32'h1000_0004, 4'hF, 32'hDEAD_BEEF, 32'h0000_0000, 1'b0);
    add_entry(PutPartialData, 32'h1000_0000, 4'h5, 32'hAABB_CCDD, 32'h0000_0000, 1'b0);
    add_entry(PutPartialData, 32'h1000_0004, 4'hC, 32'h0102_0304, 32'h0000_0000, 1'b0);
    add_entry(Get,            32'h1000_0000, 4'hF, 32'h0000_0000, 32'h11BB_33DD, 1'b0);
    add_entry(Get,            32'h1000_0004, 4'hF, 32'h0000_0000, 32'h0102_BEEF, 1'b0);
    add_entry(PutFullData,    32'h1000_001C, 4'hF, 32'hCAFE_F00D, 32'h0000_0000, 1'b0);
    add_entry(Get,            32'h1000_001C, 4'hF, 32'h0000_0000, 32'hCAFE_F00D, 1'b0);
    // Outside the window, including both edges of it.
    add_entry(Get,            32'h2000_0040, 4'hF, 32'h0000_0000, 32'h85A5_5A1A, 1'b0);
    add_entry(PutFullData,    32'h0FFF_FFFC, 4'hF, 32'h5555_AAAA, 32'hAA5A_A5A6, 1'b0);
    add_entry(Get,            32'h1000_0020, 4'hF, 32'h0000_0000, 32'hB5A5_5A7A, 1'b0);
    add_entry(PutPartialData, 32'h8000_0010, 4'h3, 32'h7777_8888, 32'h25A5_5A4A, 1'b0);
    // Unsupported opcodes, then proof that memory did not change.
    add_entry(3'h2,           32'h1000_0000, 4'hF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1);
    add_entry(3'h3,           32'h1000_0004, 4'hF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1);
    add_entry(Get,            32'h1000_0000, 4'hF, 32'h0000_0000, 32'h11BB_33DD, 1'b0);
    add_entry(Get,            32'h1000_0004, 4'hF, 32'h0000_0000, 32'h0102_BEEF, 1'b0);

    // Even slots hit the window, odd slots go outbound.
    for (int i = 0; i < RandomReqs; i++) begin
      r = $random(seed);
      if (i % 2 == 0) begin
        rnd_addr[i] = StartAddr + {27'h0, r[4:2], 2'b00};
        case (r[10:8])
          3'd0, 3'd1: rnd_op[i] = PutFullData;
          3'd2, 3'd3: rnd_op[i] = PutPartialData;
          3'd7:       rnd_op[i] = 3'h2;
          default:    rnd_op[i] = Get;
        endcase
      end else begin
        rnd_addr[i] = 32'h4000_0000 | {20'h0, r[11:2], 2'b00};
        rnd_op[i]   = r[8] ? Get : PutFullData;
      end
      rnd_mask[i] = (rnd_op[i] == PutPartialData) ? r[15:12] : 4'hF;
      rnd_data[i] = $random(seed);
    end

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_eq("host_d_valid_o", host_d_valid_o, 1'b0);
    check_eq("out_a_valid_o", out_a_valid_o, 1'b0);

    for (int i = 0; i < tbl_op.size(); i++) begin
      issue(tbl_op[i], tbl_addr[i], tbl_mask[i], tbl_data[i], tbl_exp[i], tbl_err[i]);
      wait_idle();
    end

    // Known contents in every word before the random mix.
    for (int w = 0; w < Depth; w++) begin
      addr = StartAddr + 32'(4 * w);
      predict_and_issue(PutFullData, addr, 4'hF, addr ^ {addr[15:0], addr[31:16]});
    end
    wait_idle();

    rand_ready = 1'b1;
    for (int i = 0; i < RandomReqs; i++) begin
      predict_and_issue(rnd_op[i], rnd_addr[i], rnd_mask[i], rnd_data[i]);
    end
    rand_ready     = 1'b0;
    host_d_ready_i = 1'b1;
    wait_idle();
    finish_run();
  end

endmodule
